// File: files.f
+incdir+source
source/access_pkg.sv
source/mem_bus_pkg.sv
source/mem_bus_if.sv
source/req_ingress.sv
source/mem_controller.sv
source/slave_bus_mux.sv
source/data_mem.sv
source/uart_tx.sv
source/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_mem_subsys.sv
`timescale 1ns/1ns
`include "soc_cfg.svh"

module tb_mem_subsys import access_pkg::*;;

   localparam int RAM_BYTES = 4 * 2**`RAM_WIDTH;
   localparam int MODEL_AW  = `RAM_WIDTH + 2;
   localparam int NUM_ROWS  = 35;

   typedef struct packed {
      mem_inst_type_t kind;
      logic [31:0]    addr;
      logic [31:0]    data;
      logic           rnd;   // replace data with a random word
      logic           exc;   // expected exception
   } row_t;

   // ========================================
   // stimulus table
   // ========================================
   localparam row_t ROWS [NUM_ROWS] = '{
      '{SW,  32'h000, 32'h1122_3344, 1'b0, 1'b0},
      '{SW,  32'h004, 32'h0,         1'b1, 1'b0},
      '{SW,  32'h008, 32'h0,         1'b1, 1'b0},
      '{LW,  32'h000, 32'h0,         1'b0, 1'b0},
      '{LW,  32'h004, 32'h0,         1'b0, 1'b0},
      '{LW,  32'h008, 32'h0,         1'b0, 1'b0},
      '{SW,  32'h010, 32'h0,         1'b0, 1'b0},   // clear the lane test words
      '{SW,  32'h014, 32'h0,         1'b0, 1'b0},
      '{SB,  32'h010, 32'h0000_00a5, 1'b0, 1'b0},
      '{SB,  32'h013, 32'h0000_005a, 1'b0, 1'b0},
      '{SH,  32'h016, 32'h0000_c3e1, 1'b0, 1'b0},
      '{SH,  32'h014, 32'h0,         1'b1, 1'b0},
      '{LB,  32'h010, 32'h0,         1'b0, 1'b0},
      '{LBU, 32'h010, 32'h0,         1'b0, 1'b0},
      '{LB,  32'h013, 32'h0,         1'b0, 1'b0},
      '{LH,  32'h016, 32'h0,         1'b0, 1'b0},
      '{LHU, 32'h016, 32'h0,         1'b0, 1'b0},
      '{LH,  32'h014, 32'h0,         1'b0, 1'b0},
      '{LW,  32'h010, 32'h0,         1'b0, 1'b0},
      '{LW,  32'h014, 32'h0,         1'b0, 1'b0},
      '{LBU, 32'h017, 32'h0,         1'b0, 1'b0},
      '{LH,  32'h011, 32'h0,         1'b0, 1'b1},   // misaligned
      '{LW,  32'h012, 32'h0,         1'b0, 1'b1},
      '{SH,  32'h013, 32'h0000_ffff, 1'b0, 1'b1},
      '{SW,  32'h011, 32'hdead_beef, 1'b0, 1'b1},
      '{LW,  32'h010, 32'h0,         1'b0, 1'b0},   // must be unchanged
      '{LW,  32'h800, 32'h0,         1'b0, 1'b1},   // unmapped
      '{SW,  32'h804, 32'h0,         1'b1, 1'b1},
      '{LB,  32'h1000, 32'h0,        1'b0, 1'b1},
      '{SB,  32'h400, 32'h0000_0055, 1'b0, 1'b0},   // uart, back to back
      '{SB,  32'h400, 32'h0000_00a3, 1'b0, 1'b0},
      '{SW,  32'h400, 32'h0,         1'b1, 1'b0},
      '{SB,  32'h400, 32'h0000_000f, 1'b0, 1'b0},
      '{SB,  32'h400, 32'h0000_00c6, 1'b0, 1'b0},
      '{LW,  32'h004, 32'h0,         1'b0, 1'b0}
   };

   logic           clk;
   logic           rst_n;
   logic           req_valid;
   mem_inst_type_t req_type;
   logic [31:0]    req_addr;
   logic [31:0]    req_wdata;
   logic           credit;
   logic           resp_valid;
   logic [31:0]    resp_rdata;
   logic           resp_exc;
   logic           uart_txd;

   logic [7:0]  ram_model [RAM_BYTES];
   logic [32:0] exp_q [$];    // {exc, rdata} in request order
   logic [7:0]  uart_q [$];
   logic [32:0] exp_e;
   int          credits;
   int          resp_count;
   int          cycles;
   int          timeout_limit;
   int          resp_errors;
   int          uart_errors;
   int          flow_errors;

   mem_subsys_top dut0 (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .req_valid_i  (req_valid),
      .req_type_i   (req_type),
      .req_addr_i   (req_addr),
      .req_wdata_i  (req_wdata),
      .credit_o     (credit),
      .resp_valid_o (resp_valid),
      .resp_rdata_o (resp_rdata),
      .resp_exc_o   (resp_exc),
      .uart_txd_o   (uart_txd)
   );

   always #5 clk = ~clk;

   // ========================================
   // reference model
   // ========================================
   function automatic logic [31:0] model_load(input mem_inst_type_t kind, input logic [31:0] off);
      logic [31:0] w;
      for (int b = 0; b < 4; b++) begin
         w[b*8 +: 8] = ram_model[MODEL_AW'(off + 32'(b))];
      end
      case (kind)
         LB:      return {{24{w[7]}}, w[7:0]};
         LBU:     return {24'h0, w[7:0]};
         LH:      return {{16{w[15]}}, w[15:0]};
         LHU:     return {16'h0, w[15:0]};
         default: return w;
      endcase
   endfunction

   task automatic predict_response(input row_t row, input logic [31:0] data);
      logic [31:0] off;
      logic        store;
      logic [32:0] e;
      int          n;
      off   = row.addr - `RAM_BASE;
      store = row.kind inside {SB, SH, SW};
      e     = '0;
      if (row.exc) begin
         e = {1'b1, 32'h0};
      end else if (store && row.addr[31:2] == 30'(`UART_BASE >> 2)) begin
         uart_q.push_back(data[7:0]);
      end else if (store) begin
         n = (row.kind == SB) ? 1 : ((row.kind == SH) ? 2 : 4);
         for (int b = 0; b < n; b++) begin
            ram_model[MODEL_AW'(off + 32'(b))] = data[b*8 +: 8];
         end
      end else begin
         e[31:0] = model_load(row.kind, off);
      end
      exp_q.push_back(e);   // stores answer zero
   endtask

   // credits held by the requester, counted from the pulses
   always @(posedge clk) begin
      if (!rst_n) begin
         credits <= `REQ_CREDITS;
      end else if (credit && !req_valid) begin
         credits <= credits + 1;
      end else if (!credit && req_valid) begin
         credits <= credits - 1;
      end
   end

   // ========================================
   // response and flow checks
   // ========================================
   always @(negedge clk) begin
      if (rst_n && resp_valid) begin
         resp_count++;
         assert (exp_q.size() != 0) else begin
            flow_errors++;
            $display("response at %0t without an outstanding request", $time);
         end
         if (exp_q.size() != 0) begin
            exp_e = exp_q.pop_front();
            assert (resp_rdata === exp_e[31:0]) else begin
               resp_errors++;
               $display("FAILED t=%0t resp_rdata_o: got %h expected %h",
                        $time, resp_rdata, exp_e[31:0]);
            end
            assert (resp_exc === exp_e[32]) else begin
               resp_errors++;
               $display("FAILED t=%0t resp_exc_o: got %b expected %b", $time, resp_exc, exp_e[32]);
            end
         end
      end
      assert (credits >= 0 && credits <= `REQ_CREDITS) else begin
         flow_errors++;
         $display("credit count %0d out of range at %0t", credits, $time);
      end
   end

   // sample each frame in the middle of its bits
   initial begin : uart_monitor
      logic [7:0] rx;
      logic [7:0] exp_b;
      while (rst_n !== 1'b1) @(negedge clk);
      forever begin
         @(negedge clk);
         if (uart_txd === 1'b0) begin
            repeat (`UART_DIV / 2) @(negedge clk);
            for (int k = 0; k < 8; k++) begin
               repeat (`UART_DIV) @(negedge clk);
               rx = {uart_txd, rx[7:1]};   // lsb first
            end
            repeat (`UART_DIV) @(negedge clk);
            assert (uart_txd === 1'b1) else begin
               uart_errors++;
               $display("stop bit missing on uart_txd_o at %0t", $time);
            end
            assert (uart_q.size() != 0) else begin
               uart_errors++;
               $display("byte %h sent on uart_txd_o that was never written", rx);
            end
            if (uart_q.size() != 0) begin
               exp_b = uart_q.pop_front();
               assert (rx === exp_b) else begin
                  uart_errors++;
                  $display("FAILED t=%0t uart_txd_o: got %h expected %h", $time, rx, exp_b);
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == timeout_limit) begin
         $display("timeout after %0d cycles, %0d of %0d responses", cycles, resp_count, NUM_ROWS);
         $display("errors: response %0d, uart %0d, flow %0d", resp_errors, uart_errors,
                  flow_errors);
         $display("Test FAILED");
         $finish;
      end
   end

   // ========================================
   // stimulus
   // ========================================
   initial begin : stimulus
      row_t        row;
      logic [31:0] data;
      int          uart_bytes;
      clk       = 1'b0;
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req_type  = LB;
      req_addr  = '0;
      req_wdata = '0;
      void'($urandom(32'h803a_af52));
      uart_bytes = 0;
      for (int j = 0; j < NUM_ROWS; j++) begin
         if (ROWS[j].addr[31:2] == 30'(`UART_BASE >> 2)) begin
            uart_bytes++;
         end
      end
      timeout_limit = 10 + 40 * NUM_ROWS + 12 * `UART_DIV * uart_bytes;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int i = 0; i < NUM_ROWS; i++) begin
         while (credits == 0) begin
            req_valid = 1'b0;
            @(posedge clk);
            #1;
         end
         row       = ROWS[i];
         data      = row.rnd ? $urandom : row.data;
         req_type  = row.kind;
         req_addr  = row.addr;
         req_wdata = data;
         req_valid = 1'b1;
         predict_response(row, data);
         @(posedge clk);
         #1;
      end
      req_valid = 1'b0;
      while (resp_count < NUM_ROWS || uart_q.size() != 0) @(posedge clk);
      repeat (5) @(posedge clk);
      assert (resp_count == NUM_ROWS && exp_q.size() == 0) else begin
         flow_errors++;
         $display("%0d responses for %0d requests", resp_count, NUM_ROWS);
      end
      $display("errors: response %0d, uart %0d, flow %0d", resp_errors, uart_errors, flow_errors);
      if (resp_errors + uart_errors + flow_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: source/mem_subsys_top.sv
`timescale 1ns/1ns
`include "soc_cfg.svh"

module mem_subsys_top import access_pkg::*, mem_bus_pkg::*; (
   input  logic           clk_i,
   input  logic           rst_n_i,
   input  logic           req_valid_i,
   input  mem_inst_type_t req_type_i,
   input  logic [31:0]    req_addr_i,
   input  logic [31:0]    req_wdata_i,
   output logic           credit_o,
   output logic           resp_valid_o,
   output logic [31:0]    resp_rdata_o,
   output logic           resp_exc_o,
   output logic           uart_txd_o
);

   access_req_t  req;
   access_req_t  head;
   logic         head_valid;
   logic         pop;
   logic         unmapped;
   access_resp_t resp;

   assign req.kind     = req_type_i;
   assign req.addr     = req_addr_i;
   assign req.wdata    = req_wdata_i;
   assign resp_rdata_o = resp.rdata;
   assign resp_exc_o   = resp.exc;

   mem_bus_if bus_ctrl ();
   mem_bus_if bus_ram ();
   mem_bus_if bus_uart ();

   req_ingress ingress0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (req_valid_i),
      .req_i        (req),
      .pop_i        (pop),
      .head_o       (head),
      .head_valid_o (head_valid),
      .credit_o     (credit_o)
   );

   mem_controller ctrl0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .head_i       (head),
      .head_valid_i (head_valid),
      .pop_o        (pop),
      .bus          (bus_ctrl.master),
      .unmapped_i   (unmapped),
      .resp_valid_o (resp_valid_o),
      .resp_o       (resp)
   );

   slave_bus_mux #(
      .TCmd    (mem_cmd_t),
      .TResult (mem_result_t),
      .BASE1   (`RAM_BASE >> 2),
      .SIZE1   (2**`RAM_WIDTH),
      .BASE2   (`UART_BASE >> 2),
      .SIZE2   (1)
   ) mux0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .up         (bus_ctrl.slave),
      .dn1        (bus_ram.master),
      .dn2        (bus_uart.master),
      .unmapped_o (unmapped)
   );

   data_mem #(.WIDTH(`RAM_WIDTH)) ram0 (
      .clk_i (clk_i),
      .bus   (bus_ram.slave)
   );

   uart_tx #(.DIV(`UART_DIV)) uart0 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bus     (bus_uart.slave),
      .txd_o   (uart_txd_o)
   );

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import mem_bus_pkg::*; #(
   parameter int DIV = 8   // clocks per bit
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   mem_bus_if.slave bus,
   output logic     txd_o
);

   localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

   logic [9:0]       shift_q;   // stop, data, start
   logic [3:0]       bit_cnt_q;
   logic [DIV_W-1:0] div_q;
   logic             busy_q;
   logic             start;
   logic             bit_end;
   mem_result_t      rd_q;

   assign start   = bus.cmd.mem_write & ~busy_q;
   assign bit_end = (div_q == DIV_W'(DIV - 1));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         shift_q   <= '1;   // line idles high
         bit_cnt_q <= '0;
         div_q     <= '0;
         busy_q    <= 1'b0;
      end else if (start) begin
         shift_q   <= {1'b1, bus.cmd.write_data[7:0], 1'b0};
         bit_cnt_q <= '0;
         div_q     <= '0;
         busy_q    <= 1'b1;
      end else if (busy_q) begin
         if (bit_end) begin
            div_q     <= '0;
            shift_q   <= {1'b1, shift_q[9:1]};   // lsb first, refill with idle
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 4'd9) begin
               busy_q <= 1'b0;
            end
         end else begin
            div_q <= div_q + 1'b1;
         end
      end
   end

   // status read
   always_ff @(posedge clk_i) begin
      if (bus.cmd.mem_read) begin
         rd_q.read_data <= {31'b0, busy_q};
      end
   end

   assign bus.result = rd_q;
   assign bus.stall  = bus.cmd.mem_write & busy_q;  // hold the write until the frame ends
   assign txd_o      = shift_q[0];

endmodule

// File: source/data_mem.sv
`timescale 1ns/1ns

module data_mem import mem_bus_pkg::*; #(
   parameter int WIDTH = 8   // log2 of depth in words
) (
   input  logic     clk_i,
   mem_bus_if.slave bus
);

   logic [31:0]      mem [2**WIDTH];
   logic [WIDTH-1:0] index;
   mem_result_t      rd_q;

   assign index = bus.addr[WIDTH-1:0];

   always_ff @(posedge clk_i) begin
      if (bus.cmd.mem_write) begin
         for (int b = 0; b < BYTE_LANES; b++) begin
            if (bus.cmd.mask_byte[b]) begin
               mem[index][b*8 +: 8] <= bus.cmd.write_data[b*8 +: 8];
            end
         end
      end
      if (bus.cmd.mem_read) begin
         rd_q.read_data <= mem[index];  // whole word, controller picks the lane
      end
   end

   assign bus.result = rd_q;
   assign bus.stall  = 1'b0;

endmodule

// File: source/slave_bus_mux.sv
`timescale 1ns/1ns

module slave_bus_mux import mem_bus_pkg::*; #(
   parameter type         TCmd    = mem_cmd_t,
   parameter type         TResult = mem_result_t,
   parameter int unsigned BASE1   = 0,   // ranges in words
   parameter int unsigned SIZE1   = 1,
   parameter int unsigned BASE2   = 1,
   parameter int unsigned SIZE2   = 1
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   mem_bus_if.slave  up,
   mem_bus_if.master dn1,
   mem_bus_if.master dn2,
   output logic      unmapped_o
);

   logic [31:0] addr_w;
   logic        hit1;
   logic        hit2;
   logic        accept;
   logic [1:0]  sel_q;      // {dn2, dn1} of the access accepted last cycle
   logic        unmapped_q;
   TCmd         cmd1;
   TCmd         cmd2;
   TResult      result;

   assign addr_w = {2'b00, up.addr};
   assign hit1   = (addr_w - BASE1) < SIZE1;             // wraps below base
   assign hit2   = ~hit1 & ((addr_w - BASE2) < SIZE2);

   // strobes only go to the selected target
   always_comb begin
      cmd1           = up.cmd;
      cmd2           = up.cmd;
      cmd1.mem_read  = up.cmd.mem_read & hit1;
      cmd1.mem_write = up.cmd.mem_write & hit1;
      cmd2.mem_read  = up.cmd.mem_read & hit2;
      cmd2.mem_write = up.cmd.mem_write & hit2;
   end

   assign dn1.addr = WORD_ADDR_W'(addr_w - BASE1);  // target sees its local offset
   assign dn1.cmd  = cmd1;
   assign dn2.addr = WORD_ADDR_W'(addr_w - BASE2);
   assign dn2.cmd  = cmd2;

   assign up.stall = hit1 ? dn1.stall : (hit2 ? dn2.stall : 1'b0);
   assign accept   = (up.cmd.mem_read | up.cmd.mem_write) & ~up.stall;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         sel_q      <= 2'b00;
         unmapped_q <= 1'b0;
      end else begin
         sel_q      <= accept ? {hit2, hit1} : 2'b00;
         unmapped_q <= accept & ~hit1 & ~hit2;
      end
   end

   always_comb begin
      case (sel_q)
         2'b01:   result = dn1.result;
         2'b10:   result = dn2.result;
         default: result = '0;  // nothing selected reads zero
      endcase
   end

   assign up.result  = result;
   assign unmapped_o = unmapped_q;

endmodule

// File: source/mem_controller.sv
`timescale 1ns/1ns

module mem_controller import access_pkg::*, mem_bus_pkg::*; (
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  access_req_t  head_i,
   input  logic         head_valid_i,
   output logic         pop_o,
   mem_bus_if.master    bus,
   input  logic         unmapped_i,     // last accepted access hit no target
   output logic         resp_valid_o,
   output access_resp_t resp_o
);

   logic [1:0]     lane;
   logic           misaligned;
   mem_cmd_t       cmd;

   logic           resp_valid_q;
   mem_inst_type_t kind_q;
   logic [1:0]     lane_q;
   logic           misal_q;
   logic [31:0]    lane_data;
   logic [31:0]    load_data;
   logic           exc;

   // ========================================
   // issue stage
   // ========================================
   assign lane = head_i.addr[1:0];

   always_comb begin
      case (head_i.kind)
         LH, LHU, SH: misaligned = lane[0];
         LW, SW:      misaligned = (lane != 2'b00);
         default:     misaligned = 1'b0;
      endcase
   end

   always_comb begin
      cmd.mem_read   = head_valid_i & ~misaligned & is_load(head_i.kind);
      cmd.mem_write  = head_valid_i & ~misaligned & is_store(head_i.kind);
      cmd.write_data = head_i.wdata << {lane, 3'b000};  // move onto byte lane
      case (head_i.kind)
         LB, LBU, SB: cmd.mask_byte = 4'b0001 << lane;
         LH, LHU, SH: cmd.mask_byte = 4'b0011 << lane;
         default:     cmd.mask_byte = 4'b1111;
      endcase
   end

   assign bus.addr = head_i.addr[31:2];
   assign bus.cmd  = cmd;

   // a misaligned access never reaches the bus, so it cannot stall
   assign pop_o = head_valid_i & (misaligned | ~bus.stall);

   // ========================================
   // response stage
   // ========================================
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         resp_valid_q <= 1'b0;
      end else begin
         resp_valid_q <= pop_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pop_o) begin
         kind_q  <= head_i.kind;
         lane_q  <= lane;
         misal_q <= misaligned;
      end
   end

   assign lane_data = bus.result.read_data >> {lane_q, 3'b000};

   always_comb begin
      case (kind_q)
         LB:      load_data = {{24{lane_data[7]}}, lane_data[7:0]};
         LBU:     load_data = {24'b0, lane_data[7:0]};
         LH:      load_data = {{16{lane_data[15]}}, lane_data[15:0]};
         LHU:     load_data = {16'b0, lane_data[15:0]};
         LW:      load_data = lane_data;
         default: load_data = '0;  // stores answer with zero
      endcase
   end

   assign exc          = misal_q | unmapped_i;
   assign resp_valid_o = resp_valid_q;
   assign resp_o.rdata = exc ? '0 : load_data;
   assign resp_o.exc   = exc;

endmodule

// File: source/req_ingress.sv
`timescale 1ns/1ns
`include "soc_cfg.svh"

module req_ingress import access_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        req_valid_i,
   input  access_req_t req_i,
   input  logic        pop_i,
   output access_req_t head_o,
   output logic        head_valid_o,
   output logic        credit_o
);

   localparam int DEPTH = `REQ_CREDITS;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   access_req_t      queue_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0]   count_q;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign head_valid_o = (count_q != '0);
   assign push         = req_valid_i && (count_q != (PTR_W+1)'(DEPTH));  // credits keep it from full
   assign pop          = pop_i && head_valid_o;
   assign head_o       = queue_q[rd_ptr_q];  // oldest entry

   always_ff @(posedge clk_i) begin
      if (push) begin
         queue_q[wr_ptr_q] <= req_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         credit_o <= 1'b0;
      end else begin
         credit_o <= pop;  // slot freed, hand the credit back
         if (push) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// File: source/mem_bus_if.sv
`timescale 1ns/1ns

// one bus channel between a master and a slave
interface mem_bus_if import mem_bus_pkg::*; #(
   parameter type TCmd    = mem_cmd_t,
   parameter type TResult = mem_result_t
);

   logic [WORD_ADDR_W-1:0] addr;
   TCmd                    cmd;
   TResult                 result;
   logic                   stall;   // target cannot take the command this cycle

   modport master (
      output addr,
      output cmd,
      input  result,
      input  stall
   );

   modport slave (
      input  addr,
      input  cmd,
      output result,
      output stall
   );

endinterface

// File: source/mem_bus_pkg.sv
package mem_bus_pkg;

   localparam int WORD_ADDR_W = 30;  // word address, byte offset dropped
   localparam int BYTE_LANES  = 4;

   // command driven by the bus master, data already on its byte lane
   typedef struct packed {
      logic [BYTE_LANES-1:0] mask_byte;
      logic                  mem_read;
      logic                  mem_write;
      logic [31:0]           write_data;
   } mem_cmd_t;

   // returned by the target one cycle after acceptance
   typedef struct packed {
      logic [31:0] read_data;
   } mem_result_t;

endpackage

// File: source/access_pkg.sv
package access_pkg;

   // load/store kinds as seen by the requester
   typedef enum logic [3:0] {LB, LH, LW, LBU, LHU, SB, SH, SW} mem_inst_type_t;

   typedef struct packed {
      mem_inst_type_t kind;
      logic [31:0]    addr;   // byte address
      logic [31:0]    wdata;  // store data, right aligned
   } access_req_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        exc;       // misaligned or unmapped
   } access_resp_t;

   function automatic logic is_load(input mem_inst_type_t kind);
      return kind inside {LB, LH, LW, LBU, LHU};
   endfunction

   function automatic logic is_store(input mem_inst_type_t kind);
      return kind inside {SB, SH, SW};
   endfunction

endpackage

// File: source/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ========================================
// memory map
// ========================================
`define RAM_WIDTH   8              // log2 of RAM size in words
`define RAM_BASE    32'h0000_0000  // byte address
`define UART_BASE   32'h0000_0400  // write sends low byte, read gives busy in bit 0

// ========================================
// flow control and serial timing
// ========================================
`define REQ_CREDITS 4              // ingress queue depth
`define UART_DIV    8              // clocks per serial bit

`endif
